//--- src/organ_pkg.sv
package organ_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================

  // divider count for one half of a tone period
  typedef logic [31:0] half_period_t;

  // signed audio sample
  typedef logic signed [7:0] sample_t;

  // signed scope speed offset
  typedef logic signed [15:0] speed_t;

  // scope sampling count shown on the displays
  typedef logic [15:0] count_t;

  // active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] segments_t;

  // ==========================================================================
  // notes
  // ==========================================================================

  // switch order, one octave
  typedef enum logic [2:0] {
    do_lo = 3'd0,
    re    = 3'd1,
    mi    = 3'd2,
    fa    = 3'd3,
    so    = 3'd4,
    la    = 3'd5,
    ti    = 3'd6,
    do_hi = 3'd7
  } note_t;

  // half period per note, in clock cycles
  localparam half_period_t note_half_period [0:7] = '{
    32'h0001_7544,
    32'h0001_4C8B,
    32'h0001_2843,
    32'h0001_17A2,
    32'h0000_F91F,
    32'h0000_DDF3,
    32'h0000_C5BB,
    32'h0000_BAA2
  };

  // square wave levels
  localparam sample_t sample_high = 8'sh7F;
  localparam sample_t sample_low  = 8'sh80;

  // ==========================================================================
  // timing
  // ==========================================================================

  localparam int default_ms_cycles   = 50000;
  localparam int ms_per_event_window = 100;
  localparam int ms_per_display_tick = 500;

  // millisecond counters
  typedef logic [$clog2(ms_per_event_window)-1:0] window_cnt_t;
  typedef logic [$clog2(ms_per_display_tick)-1:0] display_cnt_t;

  // ==========================================================================
  // speed and panel
  // ==========================================================================

  localparam speed_t speed_step             = 16'sd100;
  localparam count_t default_sampling_count = 16'd12499;

  localparam int num_leds   = 8;
  localparam int num_digits = 6;

endpackage

//--- src/tick_generator.sv
`timescale 1ns/100ps

module tick_generator #(
  parameter int ms_cycles = organ_pkg::default_ms_cycles
) (
  input  logic CLK_50M,
  input  logic reset,
  output logic tick_ms,
  output logic tick_half_sec,
  output logic tick_sec
);

  import organ_pkg::*;

  logic [31:0]  cycle_cnt;
  display_cnt_t ms_cnt;
  logic         sec_phase;
  logic         ms_hit;
  logic         half_sec_hit;

  // last cycle of a millisecond
  assign ms_hit = (cycle_cnt == 32'(ms_cycles - 1));

  // last millisecond of a half second
  assign half_sec_hit = tick_ms && (ms_cnt == display_cnt_t'(ms_per_display_tick - 1));

  // ==========================================================================
  // cycle and millisecond counters
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      cycle_cnt     <= '0;
      ms_cnt        <= '0;
      sec_phase     <= 1'b0;
      tick_ms       <= 1'b0;
      tick_half_sec <= 1'b0;
      tick_sec      <= 1'b0;
    end
    else
    begin
      // wrap at one millisecond
      if (ms_hit)
        cycle_cnt <= '0;
      else
        cycle_cnt <= cycle_cnt + 32'd1;
      tick_ms <= ms_hit;

      // count ms strobes up to half a second
      if (half_sec_hit)
        ms_cnt <= '0;
      else if (tick_ms)
        ms_cnt <= ms_cnt + display_cnt_t'(1);
      tick_half_sec <= half_sec_hit;

      // every second half-second strobe
      if (half_sec_hit)
        sec_phase <= ~sec_phase;
      tick_sec <= half_sec_hit && sec_phase;
    end
  end

endmodule

//--- src/key_conditioner.sv
`timescale 1ns/100ps

module key_conditioner (
  input  logic       CLK_50M,
  input  logic       reset,
  input  logic       tick_ms,
  input  logic [2:0] keys,
  output logic       up_event,
  output logic       down_event,
  output logic       clear_level
);

  import organ_pkg::*;

  // pressed = 1 after inversion
  logic [2:0]  key_meta;
  logic [2:0]  key_sync;
  window_cnt_t win_cnt;
  logic        window_end;

  // ==========================================================================
  // key synchroniser
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      // keys are active low
      key_meta <= ~keys;
      key_sync <= key_meta;
    end
  end

  // clear passes through as a level, two flops behind the pin
  assign clear_level = key_sync[2];

  // ==========================================================================
  // event window
  // ==========================================================================

  // last ms of the window
  assign window_end = tick_ms && (win_cnt == window_cnt_t'(ms_per_event_window - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      win_cnt    <= '0;
      up_event   <= 1'b0;
      down_event <= 1'b0;
    end
    else
    begin
      if (window_end)
        win_cnt <= '0;
      else if (tick_ms)
        win_cnt <= win_cnt + window_cnt_t'(1);

      // held keys sampled once per window
      // short presses between window ends are missed
      up_event   <= window_end && key_sync[0];
      down_event <= window_end && key_sync[1];
    end
  end

endmodule

//--- src/tone_generator.sv
`timescale 1ns/100ps

module tone_generator (
  input  logic              CLK_50M,
  input  logic              reset,
  input  organ_pkg::note_t  note_sel,
  input  logic              audio_enable,
  output organ_pkg::sample_t audio_sample
);

  import organ_pkg::*;

  half_period_t half_period;
  half_period_t cycle_cnt;
  logic         tone_level;
  logic         half_done;

  // table lookup for the selected note
  assign half_period = note_half_period[note_sel];

  // at or above, so a shorter note cuts in at once
  assign half_done = (cycle_cnt >= (half_period - half_period_t'(1)));

  // ==========================================================================
  // clock divider
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      cycle_cnt  <= '0;
      tone_level <= 1'b0;
    end
    else if (half_done)
    begin
      // half period over, flip the wave
      cycle_cnt  <= '0;
      tone_level <= ~tone_level;
    end
    else
    begin
      cycle_cnt <= cycle_cnt + half_period_t'(1);
    end
  end

  // ==========================================================================
  // sample shaping
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      audio_sample <= '0;
    else if (!audio_enable)
      // silence
      audio_sample <= '0;
    else if (tone_level)
      audio_sample <= sample_high;
    else
      audio_sample <= sample_low;
  end

endmodule

//--- src/scope_speed_control.sv
`timescale 1ns/100ps

module scope_speed_control (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic              up_event,
  input  logic              down_event,
  input  logic              clear_level,
  output organ_pkg::count_t sampling_count
);

  import organ_pkg::*;

  speed_t speed;

  // ==========================================================================
  // speed register
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      speed <= '0;
    end
    else if (clear_level)
    begin
      // clear key beats any step
      speed <= '0;
    end
    else
    begin
      // both at once cancel out
      case ({up_event, down_event})
        2'b10:   speed <= speed + speed_step;
        2'b01:   speed <= speed - speed_step;
        default: speed <= speed;
      endcase
    end
  end

  // ==========================================================================
  // sampling count
  // ==========================================================================

  // offset from default count, wraps in 16 bits
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sampling_count <= default_sampling_count;
    else
      sampling_count <= default_sampling_count + count_t'(speed);
  end

endmodule

//--- src/hex_display.sv
`timescale 1ns/100ps

module hex_display (
  input  logic                                            CLK_50M,
  input  logic                                            reset,
  input  logic                                            tick_half_sec,
  input  organ_pkg::count_t                               sampling_count,
  output organ_pkg::segments_t [organ_pkg::num_digits-1:0] hex_segments
);

  import organ_pkg::*;

  // one nibble per digit
  logic [4*num_digits-1:0] shown_value;

  // nibble to active low segments, gfedcba
  function automatic segments_t decode_nibble(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'hA:    return 7'h08;
      4'hB:    return 7'h03;
      4'hC:    return 7'h46;
      4'hD:    return 7'h21;
      4'hE:    return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // ==========================================================================
  // capture at 2 Hz
  // ==========================================================================

  // slow capture keeps the digits steady
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      shown_value <= '0;
    else if (tick_half_sec)
      shown_value <= {(4*num_digits)'(sampling_count)};
  end

  // ==========================================================================
  // segment decode
  // ==========================================================================

  // digit 0 is the lowest nibble
  always_comb
  begin
    for (int i = 0; i < num_digits; i++)
    begin
      hex_segments[i] = decode_nibble(shown_value[4*i +: 4]);
    end
  end

endmodule

//--- src/led_bouncer.sv
`timescale 1ns/100ps

module led_bouncer (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic                          tick_sec,
  output logic [organ_pkg::num_leds-1:0] leds
);

  import organ_pkg::*;

  logic [$clog2(num_leds)-1:0] position;
  // high while moving toward position 0
  logic                        moving_down;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      position    <= '0;
      moving_down <= 1'b0;
    end
    else if (tick_sec)
    begin
      if (position == '1)
      begin
        // top end, turn around
        moving_down <= 1'b1;
        position    <= position - 1'b1;
      end
      else if (position == '0)
      begin
        // bottom end, turn around
        moving_down <= 1'b0;
        position    <= position + 1'b1;
      end
      else if (moving_down)
        position <= position - 1'b1;
      else
        position <= position + 1'b1;
    end
  end

  // one lit LED
  assign leds = num_leds'(1) << position;

endmodule

//--- src/basic_organ_top.sv
`timescale 1ns/100ps

module basic_organ_top #(
  parameter int ms_cycles = organ_pkg::default_ms_cycles
) (
  input  logic                                            CLK_50M,
  input  logic                                            reset,
  input  logic [2:0]                                      keys,
  input  organ_pkg::note_t                                note_sel,
  input  logic                                            audio_enable,
  output organ_pkg::sample_t                              audio_sample,
  output logic [organ_pkg::num_leds-1:0]                  leds,
  output organ_pkg::segments_t [organ_pkg::num_digits-1:0] hex_segments
);

  import organ_pkg::*;

  // enable strobes
  logic   tick_ms;
  logic   tick_half_sec;
  logic   tick_sec;

  // speed panel
  logic   up_event;
  logic   down_event;
  logic   clear_level;
  count_t sampling_count;

  // ==========================================================================
  // timing
  // ==========================================================================

  tick_generator #(
    .ms_cycles(ms_cycles)
  ) tick_gen0 (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .tick_ms      (tick_ms),
    .tick_half_sec(tick_half_sec),
    .tick_sec     (tick_sec)
  );

  // ==========================================================================
  // scope speed panel
  // ==========================================================================

  key_conditioner key_cond0 (
    .CLK_50M    (CLK_50M),
    .reset      (reset),
    .tick_ms    (tick_ms),
    .keys       (keys),
    .up_event   (up_event),
    .down_event (down_event),
    .clear_level(clear_level)
  );

  scope_speed_control speed_ctrl0 (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .up_event      (up_event),
    .down_event    (down_event),
    .clear_level   (clear_level),
    .sampling_count(sampling_count)
  );

  hex_display hex_disp0 (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .tick_half_sec (tick_half_sec),
    .sampling_count(sampling_count),
    .hex_segments  (hex_segments)
  );

  // LEDs and audio
  led_bouncer led_bounce0 (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .tick_sec(tick_sec),
    .leds    (leds)
  );

  tone_generator tone_gen0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .note_sel    (note_sel),
    .audio_enable(audio_enable),
    .audio_sample(audio_sample)
  );

endmodule

//--- verif/basic_organ_properties.sv
`timescale 1ns/100ps

module basic_organ_properties (
  input logic                         CLK_50M,
  input logic                         reset,
  input logic                         tick_ms,
  input logic                         tick_half_sec,
  input logic                         tick_sec,
  input logic                         up_event,
  input logic                         down_event,
  input logic                         audio_enable,
  input organ_pkg::sample_t           audio_sample,
  input logic [organ_pkg::num_leds-1:0] leds
);

  import organ_pkg::*;

  // read by the testbench at the end of the run
  int assert_failures = 0;

  // ==========================================================================
  // strobes
  // ==========================================================================

  tick_ms_single: assert property (@(posedge CLK_50M) disable iff (reset)
    tick_ms |=> !tick_ms)
    else
    begin
      $error("tick_ms high for more than one cycle");
      assert_failures = assert_failures + 1;
    end

  tick_half_sec_single: assert property (@(posedge CLK_50M) disable iff (reset)
    tick_half_sec |=> !tick_half_sec)
    else
    begin
      $error("tick_half_sec high for more than one cycle");
      assert_failures = assert_failures + 1;
    end

  tick_sec_single: assert property (@(posedge CLK_50M) disable iff (reset)
    tick_sec |=> !tick_sec)
    else
    begin
      $error("tick_sec high for more than one cycle");
      assert_failures = assert_failures + 1;
    end

  // at most one event per window
  up_event_single: assert property (@(posedge CLK_50M) disable iff (reset)
    up_event |=> !up_event)
    else
    begin
      $error("up_event on two cycles in a row");
      assert_failures = assert_failures + 1;
    end

  down_event_single: assert property (@(posedge CLK_50M) disable iff (reset)
    down_event |=> !down_event)
    else
    begin
      $error("down_event on two cycles in a row");
      assert_failures = assert_failures + 1;
    end

  // ==========================================================================
  // outputs
  // ==========================================================================

  leds_one_hot: assert property (@(posedge CLK_50M) disable iff (reset)
    $onehot(leds))
    else
    begin
      $error("leds not one-hot");
      assert_failures = assert_failures + 1;
    end

  // sample is registered, so silence shows one cycle later
  audio_silent: assert property (@(posedge CLK_50M) disable iff (reset)
    !audio_enable |=> (audio_sample == 8'sh00))
    else
    begin
      $error("audio_sample not zero with audio_enable low");
      assert_failures = assert_failures + 1;
    end

endmodule

bind basic_organ_top basic_organ_properties props0 (
  .CLK_50M      (CLK_50M),
  .reset        (reset),
  .tick_ms      (tick_ms),
  .tick_half_sec(tick_half_sec),
  .tick_sec     (tick_sec),
  .up_event     (up_event),
  .down_event   (down_event),
  .audio_enable (audio_enable),
  .audio_sample (audio_sample),
  .leds         (leds)
);

//--- verif/organ_tests.svh
// ============================================================================
// reporting and reference models
// ============================================================================

task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
  error_count++;
  $display("ERROR %s: expected %0h, actual %0h", test_name, expected, actual);
endtask

task automatic report_timeout(input string test_name, input string what);
  timeout_count++;
  $display("timeout in %s: %s", test_name, what);
endtask

// active low segments from the lit segments of each hex glyph
function automatic segments_t digit_pattern(input logic [3:0] digit);
  logic [6:0] lit;
  case (digit)
    4'h0:    lit = 7'h3F;
    4'h1:    lit = 7'h06;
    4'h2:    lit = 7'h5B;
    4'h3:    lit = 7'h4F;
    4'h4:    lit = 7'h66;
    4'h5:    lit = 7'h6D;
    4'h6:    lit = 7'h7D;
    4'h7:    lit = 7'h07;
    4'h8:    lit = 7'h7F;
    4'h9:    lit = 7'h6F;
    4'hA:    lit = 7'h77;
    4'hB:    lit = 7'h7C;
    4'hC:    lit = 7'h39;
    4'hD:    lit = 7'h5E;
    4'hE:    lit = 7'h79;
    default: lit = 7'h71;
  endcase
  return ~lit;
endfunction

// expected half period per note in clock cycles
function automatic int expected_half_period(input note_t note);
  case (note)
    do_lo:   return 32'h0001_7544;
    re:      return 32'h0001_4C8B;
    mi:      return 32'h0001_2843;
    fa:      return 32'h0001_17A2;
    so:      return 32'h0000_F91F;
    la:      return 32'h0000_DDF3;
    ti:      return 32'h0000_C5BB;
    default: return 32'h0000_BAA2;
  endcase
endfunction

// segments back to a 24 bit value
// valid drops on an unknown glyph
task automatic read_display(output logic [23:0] value, output bit valid);
  int d;
  int n;
  bit hit;
  value = '0;
  valid = 1'b1;
  for (d = 0; d < num_digits; d++)
  begin
    hit = 1'b0;
    for (n = 0; n < 16; n++)
    begin
      if (!hit && hex_segments[d] === digit_pattern(4'(n)))
      begin
        value[4*d +: 4] = 4'(n);
        hit = 1'b1;
      end
    end
    if (!hit)
      valid = 1'b0;
  end
endtask

// ============================================================================
// bounded waits
// ============================================================================

// step cycles and log every new display value
task automatic watch_display(input int cycles);
  logic [23:0] value;
  bit          valid;
  bit          bad_seen;
  int          i;
  bad_seen = 1'b0;
  for (i = 0; i < cycles; i++)
  begin
    @(negedge CLK_50M);
    read_display(value, valid);
    if (!valid && !bad_seen)
    begin
      error_count++;
      bad_seen = 1'b1;
      $display("speed_stepping: a digit shows a pattern that is no hex glyph");
    end
    else if (valid && value != last_shown)
    begin
      shown_values.push_back(value);
      last_shown = value;
    end
  end
endtask

task automatic wait_for_display(input logic [23:0] expected, input int limit,
                                output bit found);
  logic [23:0] value;
  bit          valid;
  int          i;
  found = 1'b0;
  i = 0;
  while (!found && i < limit)
  begin
    @(negedge CLK_50M);
    i++;
    read_display(value, valid);
    if (valid && value == expected)
      found = 1'b1;
  end
endtask

task automatic next_display_change(input int limit, output logic [23:0] value,
                                   output bit found);
  logic [23:0] start_value;
  bit          valid;
  int          i;
  read_display(start_value, valid);
  value = start_value;
  found = 1'b0;
  i = 0;
  while (!found && i < limit)
  begin
    @(negedge CLK_50M);
    i++;
    read_display(value, valid);
    if (valid && value != start_value)
      found = 1'b1;
  end
endtask

// cycles counted from the call edge to the edge that sees the change
task automatic next_sample_change(input int limit, output int cycles, output bit changed);
  sample_t start_value;
  start_value = audio_sample;
  cycles = 0;
  changed = 1'b0;
  while (!changed && cycles < limit)
  begin
    @(negedge CLK_50M);
    cycles++;
    if (audio_sample != start_value)
      changed = 1'b1;
  end
endtask

task automatic next_led_change(input int limit, output bit changed);
  logic [num_leds-1:0] start_value;
  int                  i;
  start_value = leds;
  changed = 1'b0;
  i = 0;
  while (!changed && i < limit)
  begin
    @(negedge CLK_50M);
    i++;
    if (leds != start_value)
      changed = 1'b1;
  end
endtask

// ============================================================================
// directed tests
// ============================================================================

task automatic reset_state_test();
  int d;
  if (audio_sample !== 8'h00)
    report_mismatch("reset_state audio", 32'h0, {24'h0, audio_sample});
  if (leds !== 8'h01)
    report_mismatch("reset_state leds", 32'h01, {24'h0, leds});
  // captured value starts at zero on every digit
  for (d = 0; d < num_digits; d++)
  begin
    if (hex_segments[d] !== digit_pattern(4'h0))
      report_mismatch("reset_state digit", {25'h0, digit_pattern(4'h0)},
                      {25'h0, hex_segments[d]});
  end
endtask

task automatic speed_stepping_test();
  bit found;
  bit order_ok;
  int steps_up;
  int steps_down;
  int offset;
  int peak;
  int i;
  shown_values.delete();
  // first refresh brings up the default count
  wait_for_display(24'(base_count), 2 * refresh_cycles + 100, found);
  if (!found)
    report_timeout("speed_stepping", "display never showed the default count");
  last_shown = 24'(base_count);
  shown_values.push_back(last_shown);

  // up held for three and a half windows gives 3 or 4 events
  keys[0] = 1'b0;
  watch_display(3 * window_cycles + window_cycles / 2);
  keys[0] = 1'b1;
  // two refreshes so the final count is on show
  watch_display(2 * refresh_cycles + 100);
  steps_up = (int'(last_shown) - base_count) / speed_increment;
  if (steps_up < 3 || steps_up > 4)
    report_mismatch("speed_stepping up", 32'(base_count + 3 * speed_increment),
                    32'(last_shown));

  // down held for one and a half windows gives 1 or 2 events
  keys[1] = 1'b0;
  watch_display(window_cycles + window_cycles / 2);
  keys[1] = 1'b1;
  watch_display(2 * refresh_cycles + 100);
  steps_down = steps_up - (int'(last_shown) - base_count) / speed_increment;
  if (steps_down < 1 || steps_down > 2)
    report_mismatch("speed_stepping down",
                    32'(base_count + (steps_up - 1) * speed_increment), 32'(last_shown));

  // every value a step multiple
  // peak somewhere in the middle
  peak = 0;
  for (i = 0; i < shown_values.size(); i++)
  begin
    offset = int'(shown_values[i]) - base_count;
    if (offset < 0 || offset % speed_increment != 0)
      report_mismatch("speed_stepping multiple",
                      32'(base_count + (offset / speed_increment) * speed_increment),
                      32'(shown_values[i]));
    if (shown_values[i] > shown_values[peak])
      peak = i;
  end
  order_ok = (peak > 0) && (peak < shown_values.size() - 1);
  for (i = 0; i + 1 < shown_values.size(); i++)
  begin
    if (i < peak && shown_values[i+1] <= shown_values[i])
      order_ok = 1'b0;
    if (i >= peak && shown_values[i+1] >= shown_values[i])
      order_ok = 1'b0;
  end
  if (!order_ok)
  begin
    error_count++;
    $display("speed_stepping: displayed values do not rise and then fall");
  end
endtask

task automatic clear_key_test();
  logic [23:0] value;
  bit          found;
  // clear held until a refresh shows the result
  keys[2] = 1'b0;
  next_display_change(2 * refresh_cycles + 100, value, found);
  keys[2] = 1'b1;
  if (!found)
    report_timeout("clear", "display did not change after the clear key");
  else if (value != 24'h0030D3)
    report_mismatch("clear", 32'h0030D3, {8'h0, value});
endtask

task automatic led_bounce_test();
  bit found;
  int step;
  int position;
  int i;
  // start from position 0
  i = 0;
  while (leds != 8'h01 && i < 15 * second_cycles)
  begin
    @(negedge CLK_50M);
    i++;
  end
  found = (leds == 8'h01);
  if (!found)
    report_timeout("led_bounce", "leds never reached position 0");
  // up to 7 and back down to 0 one place per step
  for (step = 1; step <= 2 * (num_leds - 1) && found; step++)
  begin
    next_led_change(second_cycles + 100, found);
    position = (step < num_leds) ? step : 2 * (num_leds - 1) - step;
    if (!found)
      report_timeout("led_bounce", "leds stopped moving");
    else if (leds != num_leds'(1 << position))
      report_mismatch("led_bounce", 32'(1 << position), {24'h0, leds});
  end
endtask

task automatic tone_period_test();
  note_t   order [0:7];
  note_t   swap;
  sample_t prev;
  sample_t expected_next;
  int      cycles;
  int      i;
  int      j;
  bit      changed;
  // shuffled note order
  for (i = 0; i < 8; i++)
    order[i] = note_t'(i);
  for (i = 7; i > 0; i--)
  begin
    j = $urandom % (i + 1);
    swap = order[i];
    order[i] = order[j];
    order[j] = swap;
  end

  audio_enable = 1'b1;
  next_sample_change(tone_limit, cycles, changed);
  if (!changed)
    report_timeout("tone_period", "sample did not leave zero after enable");

  for (i = 0; i < 3; i++)
  begin
    note_sel = order[i];
    // first toggle after a switch is out of phase
    next_sample_change(tone_limit, cycles, changed);
    prev = audio_sample;
    next_sample_change(tone_limit, cycles, changed);
    if (!changed)
    begin
      report_timeout("tone_period", "sample stopped toggling");
    end
    else
    begin
      if (cycles != expected_half_period(order[i]))
        report_mismatch("tone_period cycles", 32'(expected_half_period(order[i])),
                        32'(cycles));
      expected_next = (prev == 8'sh7F) ? 8'sh80 : 8'sh7F;
      if (audio_sample != expected_next)
        report_mismatch("tone_period level", {24'h0, expected_next}, {24'h0, audio_sample});
    end
  end

  // silence one clock after the enable drops
  audio_enable = 1'b0;
  i = 0;
  while (audio_sample != 8'sh00 && i < 4)
  begin
    @(negedge CLK_50M);
    i++;
  end
  if (audio_sample != 8'sh00)
    report_mismatch("tone_period disable", 32'h0, {24'h0, audio_sample});
endtask

//--- verif/tb_basic_organ.sv
`timescale 1ns/100ps

module tb_basic_organ;

  import organ_pkg::*;

  // ==========================================================================
  // simulation timing
  // ==========================================================================

  // shrunk millisecond keeps the run short
  localparam int tb_ms_cycles   = 10;
  localparam int window_cycles  = 100 * tb_ms_cycles;
  localparam int refresh_cycles = 500 * tb_ms_cycles;
  localparam int second_cycles  = 2 * refresh_cycles;
  // longest note half period plus room
  localparam int tone_limit     = 200000;

  // speed panel rules
  localparam int base_count      = 12499;
  localparam int speed_increment = 100;

  // dut ports
  logic                       CLK_50M;
  logic                       reset;
  logic [2:0]                 keys;
  note_t                      note_sel;
  logic                       audio_enable;
  sample_t                    audio_sample;
  logic [num_leds-1:0]        leds;
  segments_t [num_digits-1:0] hex_segments;

  // bookkeeping
  int          error_count;
  int          timeout_count;
  // display values seen during speed stepping
  logic [23:0] shown_values [$];
  logic [23:0] last_shown;

  basic_organ_top #(
    .ms_cycles(tb_ms_cycles)
  ) dut0 (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .keys        (keys),
    .note_sel    (note_sel),
    .audio_enable(audio_enable),
    .audio_sample(audio_sample),
    .leds        (leds),
    .hex_segments(hex_segments)
  );

  // 50 MHz, 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever
      #10 CLK_50M = ~CLK_50M;
  end

  `include "organ_tests.svh"

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial
  begin
    error_count   = 0;
    timeout_count = 0;
    last_shown    = '0;
    reset         = 1'b1;
    // keys idle high
    keys          = 3'b111;
    note_sel      = do_lo;
    audio_enable  = 1'b0;
    void'($urandom(32'h6d4b57a1));

    // 8 cycles of reset, released on a falling edge
    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    reset = 1'b0;

    reset_state_test();
    speed_stepping_test();
    clear_key_test();
    led_bounce_test();
    tone_period_test();

    $display("checks done: %0d errors, %0d timeouts, %0d assertion failures",
             error_count, timeout_count, dut0.props0.assert_failures);
    if (error_count == 0 && timeout_count == 0 && dut0.props0.assert_failures == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
src/organ_pkg.sv
src/tick_generator.sv
src/key_conditioner.sv
src/tone_generator.sv
src/scope_speed_control.sv
src/hex_display.sv
src/led_bouncer.sv
src/basic_organ_top.sv
verif/basic_organ_properties.sv
verif/tb_basic_organ.sv
